// ==== Makefile ====
# Verilator build and run for the 4x4 systolic matrix multiplier

VERILATOR ?= verilator
TOP       ?= tb_matmul_4x4_systolic
FILELIST  ?= matmul_4x4_systolic.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TESTBENCH PASSED
VFLAGS    ?= --binary --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== matmul_4x4_systolic.f ====
matmul_pkg.sv
matmul_control.sv
systolic_data_setup.sv
processing_element.sv
systolic_pe_matrix.sv
output_logic.sv
matmul_4x4_systolic.sv
matmul_sva.sv
tb_matmul_4x4_systolic.sv

// ==== matmul_4x4_systolic.sv ====
// Top level of the 4x4 integer systolic matrix multiplier
// Control, input skew, PE mesh and output streaming

`timescale 1ns/1ps

module matmul_4x4_systolic (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_mat_mul,
    input  matmul_pkg::operand_vec_t a_data,
    input  matmul_pkg::operand_vec_t b_data,
    output logic                     done_mat_mul,
    output matmul_pkg::result_row_t  c_data_out,
    output logic                     c_data_available
);
    import matmul_pkg::*;

    logic                 feed_en;
    operand_vec_t         a_skew;
    operand_vec_t         b_skew;
    result_row_t          c_matrix [0:MAT_MUL_SIZE-1];

    // The cycle count is consumed inside the control block only
    matmul_control i_matmul_control (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (),
        .feed_en       (feed_en),
        .done_mat_mul  (done_mat_mul)
    );

    systolic_data_setup i_systolic_data_setup (
        .clk     (clk),
        .reset   (reset),
        .feed_en (feed_en),
        .a_data  (a_data),
        .b_data  (b_data),
        .a_skew  (a_skew),
        .b_skew  (b_skew)
    );

    // Accumulators are held clear whenever no run is in progress
    systolic_pe_matrix i_systolic_pe_matrix (
        .clk      (clk),
        .reset    (reset),
        .clear    (~start_mat_mul),
        .a_skew   (a_skew),
        .b_skew   (b_skew),
        .c_matrix (c_matrix)
    );

    output_logic i_output_logic (
        .clk              (clk),
        .reset            (reset),
        .done_mat_mul     (done_mat_mul),
        .c_matrix         (c_matrix),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available)
    );

endmodule

// ==== matmul_control.sv ====
// Run control for the systolic multiplier
// Cycle counter, operand feed window and the done pulse

`timescale 1ns/1ps

module matmul_control (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_mat_mul,
    output logic [matmul_pkg::CNT_WIDTH-1:0] clk_cnt,
    output logic                             feed_en,
    output logic                             done_mat_mul
);
    import matmul_pkg::*;

    // The counter reads 0 in the first cycle with start high and
    // stops one past the done count so that done fires only once
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            clk_cnt      <= '0;
            done_mat_mul <= 1'b0;
        end else begin
            if (clk_cnt != CNT_WIDTH'(DONE_CYCLE + 1)) begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            // Registered one count early so the pulse lines up with DONE_CYCLE
            done_mat_mul <= (clk_cnt == CNT_WIDTH'(DONE_CYCLE - 1));
        end
    end

    // One slice of A and B is taken per cycle during the first four counts
    assign feed_en = start_mat_mul && (clk_cnt < CNT_WIDTH'(MAT_MUL_SIZE));

endmodule

// ==== matmul_pkg.sv ====
// Shared sizes, widths and timing constants for the 4x4 systolic multiplier
// Operand and result word types, plus the packed slice and row types

package matmul_pkg;

    ////////////////////////////////////////////////////////////
    // Array geometry and data widths
    ////////////////////////////////////////////////////////////
    localparam int MAT_MUL_SIZE = 4;
    localparam int DWIDTH       = 8;
    localparam int CWIDTH       = 16;

    ////////////////////////////////////////////////////////////
    // Cycle counter and done timing
    ////////////////////////////////////////////////////////////
    localparam int CNT_WIDTH  = 8;
    // The mesh needs 11 cycles, the rest is margin
    localparam int DONE_CYCLE = 14;

    typedef logic [DWIDTH-1:0] operand_t;
    typedef logic [CWIDTH-1:0] result_t;

    // Element i of a slice sits at bits i*DWIDTH upward
    typedef logic [MAT_MUL_SIZE*DWIDTH-1:0] operand_vec_t;

    // Element j of a result row sits at bits j*CWIDTH upward
    typedef logic [MAT_MUL_SIZE*CWIDTH-1:0] result_row_t;

endpackage

// ==== matmul_sva.sv ====
// Concurrent timing checks on the multiplier top level
// Bound into the top level so its ports are watched directly

`timescale 1ns/1ps

module matmul_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    done_mat_mul,
    input logic                    c_data_available,
    input matmul_pkg::result_row_t c_data_out
);

    // Done is a single-cycle pulse
    done_single_pulse: assert property (
        @(posedge clk) disable iff (reset) done_mat_mul |=> !done_mat_mul
    ) else $error("done_mat_mul high for two cycles in a row");

    // One row per cycle for four cycles after done, then valid drops
    rows_after_done: assert property (
        @(posedge clk) disable iff (reset)
        done_mat_mul |=> c_data_available ##1 c_data_available ##1 c_data_available
                         ##1 c_data_available ##1 !c_data_available
    ) else $error("c_data_available not high for exactly four cycles after done");

    // Synchronous reset clears the registered outputs one cycle in
    quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!done_mat_mul && !c_data_available && c_data_out == '0)
    ) else $error("outputs active during reset");

endmodule

bind matmul_4x4_systolic matmul_sva i_matmul_sva (
    .clk              (clk),
    .reset            (reset),
    .done_mat_mul     (done_mat_mul),
    .c_data_available (c_data_available),
    .c_data_out       (c_data_out)
);

// ==== matmul_testdata.txt ====
# Each test: a name line, then A and B (8-bit hex) and expected C (16-bit hex)
# Every matrix is 16 values on one line in row-major order
identity_times_b
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
small_counting
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
01 00 02 00 00 01 00 02 03 00 01 00 00 04 00 01
000a 0012 0005 0008 001a 0026 0011 0014 002a 003a 001d 0020 003a 004e 0029 002c
all_ff_wrap
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
f804 f804 f804 f804 f804 f804 f804 f804 f804 f804 f804 f804 f804 f804 f804 f804
all_80_wrap_to_zero
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
small_mixed
02 00 01 03 04 01 00 02 00 03 02 01 01 01 01 01
01 02 00 01 03 00 01 02 02 01 03 00 00 02 01 01
0004 000b 0006 0005 0007 000c 0003 0008 000d 0004 000a 0007 0006 0005 0005 0004

// ==== output_logic.sv ====
// Result capture and row streaming
// Latches the mesh results on done, then sends one row per cycle

`timescale 1ns/1ps

module output_logic (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    done_mat_mul,
    input  matmul_pkg::result_row_t c_matrix [0:matmul_pkg::MAT_MUL_SIZE-1],
    output matmul_pkg::result_row_t c_data_out,
    output logic                    c_data_available
);
    import matmul_pkg::*;

    result_row_t                     c_latch [0:MAT_MUL_SIZE-1];
    logic [$clog2(MAT_MUL_SIZE)-1:0] row_idx;

    ////////////////////////////////////////////////////////////
    // Result snapshot
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (done_mat_mul) begin
            c_latch <= c_matrix;
        end
    end

    ////////////////////////////////////////////////////////////
    // Row sequencer
    ////////////////////////////////////////////////////////////
    // Valid rises the cycle after done and stays up for one cycle per row
    always_ff @(posedge clk) begin
        if (reset) begin
            c_data_available <= 1'b0;
            row_idx          <= '0;
        end else if (done_mat_mul) begin
            c_data_available <= 1'b1;
            row_idx          <= '0;
        end else if (c_data_available) begin
            row_idx <= row_idx + 1'b1;
            if (row_idx == MAT_MUL_SIZE - 1) begin
                c_data_available <= 1'b0;
            end
        end
    end

    // Row index wraps back to 0 after the last row, ready for the next run
    assign c_data_out = c_data_available ? c_latch[row_idx] : '0;

endmodule

// ==== processing_element.sv ====
// Single multiply-accumulate cell of the systolic mesh
// Forwards A to the east and B to the south, one register per hop

`timescale 1ns/1ps

module processing_element (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  matmul_pkg::operand_t in_a,
    input  matmul_pkg::operand_t in_b,
    output matmul_pkg::operand_t out_a,
    output matmul_pkg::operand_t out_b,
    output matmul_pkg::result_t  out_c
);
    import matmul_pkg::*;

    result_t product;

    // Full 8x8 product fits in the 16-bit accumulator word
    assign product = result_t'(in_a) * result_t'(in_b);

    // Pass-through registers toward the neighbouring cells
    always_ff @(posedge clk) begin
        if (reset) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    // Accumulator wraps modulo 2^CWIDTH and is held at zero between runs
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            out_c <= '0;
        end else begin
            out_c <= out_c + product;
        end
    end

endmodule

// ==== systolic_data_setup.sv ====
// Input skew for the systolic mesh
// Gates and registers the A column and B row slices, then delays lane i by
// i more cycles so the operands enter the mesh on a diagonal wavefront

`timescale 1ns/1ps

module systolic_data_setup (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     feed_en,
    input  matmul_pkg::operand_vec_t a_data,
    input  matmul_pkg::operand_vec_t b_data,
    output matmul_pkg::operand_vec_t a_skew,
    output matmul_pkg::operand_vec_t b_skew
);
    import matmul_pkg::*;

    ////////////////////////////////////////////////////////////
    // Per-lane delay lines
    ////////////////////////////////////////////////////////////
    // Lane i of A feeds row i of the mesh, lane i of B feeds column i.
    // Stage 0 is the input register, stages 1..i add the skew
    for (genvar i = 0; i < MAT_MUL_SIZE; i++) begin : g_lane
        operand_t a_pipe [0:i];
        operand_t b_pipe [0:i];

        always_ff @(posedge clk) begin
            if (reset) begin
                for (int s = 0; s <= i; s++) begin
                    a_pipe[s] <= '0;
                    b_pipe[s] <= '0;
                end
            end else begin
                // Zeros go in outside the feed window so the mesh adds nothing
                a_pipe[0] <= feed_en ? a_data[i*DWIDTH +: DWIDTH] : '0;
                b_pipe[0] <= feed_en ? b_data[i*DWIDTH +: DWIDTH] : '0;
                for (int s = 1; s <= i; s++) begin
                    a_pipe[s] <= a_pipe[s-1];
                    b_pipe[s] <= b_pipe[s-1];
                end
            end
        end

        assign a_skew[i*DWIDTH +: DWIDTH] = a_pipe[i];
        assign b_skew[i*DWIDTH +: DWIDTH] = b_pipe[i];
    end

endmodule

// ==== systolic_pe_matrix.sv ====
// 4x4 mesh of processing elements
// A operands travel along rows, B operands down columns

`timescale 1ns/1ps

module systolic_pe_matrix (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear,
    input  matmul_pkg::operand_vec_t a_skew,
    input  matmul_pkg::operand_vec_t b_skew,
    output matmul_pkg::result_row_t  c_matrix [0:matmul_pkg::MAT_MUL_SIZE-1]
);
    import matmul_pkg::*;

    // Registered outputs of each cell. The east column of a_hop and the
    // south row of b_hop leave the mesh and go nowhere
    operand_t a_hop [0:MAT_MUL_SIZE-1][0:MAT_MUL_SIZE-1];
    operand_t b_hop [0:MAT_MUL_SIZE-1][0:MAT_MUL_SIZE-1];

    for (genvar r = 0; r < MAT_MUL_SIZE; r++) begin : g_row
        for (genvar c = 0; c < MAT_MUL_SIZE; c++) begin : g_col
            operand_t pe_in_a;
            operand_t pe_in_b;
            result_t  pe_c;

            // West edge takes the skewed A lane, others take the left neighbour
            if (c == 0) begin : g_a_edge
                assign pe_in_a = a_skew[r*DWIDTH +: DWIDTH];
            end else begin : g_a_chain
                assign pe_in_a = a_hop[r][c-1];
            end

            // North edge takes the skewed B lane, others take the cell above
            if (r == 0) begin : g_b_edge
                assign pe_in_b = b_skew[c*DWIDTH +: DWIDTH];
            end else begin : g_b_chain
                assign pe_in_b = b_hop[r-1][c];
            end

            processing_element i_pe (
                .clk   (clk),
                .reset (reset),
                .clear (clear),
                .in_a  (pe_in_a),
                .in_b  (pe_in_b),
                .out_a (a_hop[r][c]),
                .out_b (b_hop[r][c]),
                .out_c (pe_c)
            );

            assign c_matrix[r][c*CWIDTH +: CWIDTH] = pe_c;
        end
    end

endmodule

// ==== tb_matmul_4x4_systolic.sv ====
// Testbench for the 4x4 systolic matrix multiplier
// Reads A, B and expected C per test from the data file, runs each test and
// checks the done timing and the four streamed result rows

`timescale 1ns/1ps

module tb_matmul_4x4_systolic;
    import matmul_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    logic         clk;
    logic         reset;
    logic         start_mat_mul;
    operand_vec_t a_data;
    operand_vec_t b_data;
    logic         done_mat_mul;
    result_row_t  c_data_out;
    logic         c_data_available;

    int       errors;
    int       tests;
    integer   seed;
    string    test_name;
    operand_t a_mat [0:15];
    operand_t b_mat [0:15];
    result_t  c_exp [0:15];

    always #20 clk = ~clk;

    matmul_4x4_systolic i_matmul_4x4_systolic (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .a_data           (a_data),
        .b_data           (b_data),
        .done_mat_mul     (done_mat_mul),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available)
    );

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("[FAIL] %0s %0s: expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR in %0s: %0s", test_name, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Slice packing with element i at bits i*width upward
    ////////////////////////////////////////////////////////////
    // Column k of A, element i is A[i][k]
    function automatic operand_vec_t a_column(input int k);
        operand_vec_t v;
        for (int i = 0; i < MAT_MUL_SIZE; i++) begin
            v[i*DWIDTH +: DWIDTH] = a_mat[i*MAT_MUL_SIZE + k];
        end
        return v;
    endfunction

    // Row k of B, element j is B[k][j]
    function automatic operand_vec_t b_row(input int k);
        operand_vec_t v;
        for (int j = 0; j < MAT_MUL_SIZE; j++) begin
            v[j*DWIDTH +: DWIDTH] = b_mat[k*MAT_MUL_SIZE + j];
        end
        return v;
    endfunction

    function automatic result_row_t expected_row(input int r);
        result_row_t v;
        for (int j = 0; j < MAT_MUL_SIZE; j++) begin
            v[j*CWIDTH +: CWIDTH] = c_exp[r*MAT_MUL_SIZE + j];
        end
        return v;
    endfunction

    // Reads 16 A, 16 B and 16 expected C values of one test
    task automatic read_matrices(input integer fd, output bit ok);
        integer      code;
        logic [31:0] val;
        ok = 1'b1;
        for (int n = 0; n < 48; n++) begin
            code = $fscanf(fd, "%h", val);
            if (code != 1) begin
                report_problem("test record in the data file is incomplete");
                ok = 1'b0;
                break;
            end
            if (n < 16) begin
                a_mat[n] = val[7:0];
            end else if (n < 32) begin
                b_mat[n-16] = val[7:0];
            end else begin
                c_exp[n-32] = val[15:0];
            end
        end
    endtask

    // Outputs must stay quiet before the first run
    task automatic check_idle();
        for (int n = 0; n < 4; n++) begin
            @(negedge clk);
            if (done_mat_mul !== 1'b0) report_problem("done_mat_mul high while idle");
            if (c_data_available !== 1'b0) report_problem("c_data_available high while idle");
            if (c_data_out !== '0) report_mismatch("idle c_data_out", '0, c_data_out);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One run of the multiplier
    ////////////////////////////////////////////////////////////
    task automatic run_matrix();
        int cyc;
        int waited;
        int done_cyc;
        // Slice k is driven so that the DUT samples it while its counter reads k
        for (int k = 0; k < MAT_MUL_SIZE; k++) begin
            @(posedge clk);
            start_mat_mul <= 1'b1;
            a_data        <= a_column(k);
            b_data        <= b_row(k);
        end
        @(posedge clk);
        a_data <= '0;
        b_data <= '0;
        // Cycle index counts from the first cycle with start high
        cyc    = MAT_MUL_SIZE;
        waited = 0;
        @(negedge clk);
        while (!done_mat_mul && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cyc++;
            waited++;
        end
        if (!done_mat_mul) begin
            report_problem("timed out waiting for done_mat_mul");
        end else begin
            if (cyc != DONE_CYCLE) report_mismatch("done cycle", DONE_CYCLE, cyc);
            done_cyc = cyc;
            waited   = 0;
            @(negedge clk);
            cyc++;
            while (!c_data_available && waited < TIMEOUT_CYCLES) begin
                if (done_mat_mul) report_problem("done_mat_mul pulsed more than once");
                @(negedge clk);
                cyc++;
                waited++;
            end
            if (!c_data_available) begin
                report_problem("timed out waiting for c_data_available");
            end else begin
                if (cyc != done_cyc + 1) report_mismatch("valid start cycle", done_cyc + 1, cyc);
                for (int r = 0; r < MAT_MUL_SIZE; r++) begin
                    if (!c_data_available) report_problem("c_data_available dropped early");
                    if (c_data_out !== expected_row(r)) begin
                        report_mismatch($sformatf("row %0d", r), expected_row(r), c_data_out);
                    end
                    if (done_mat_mul) report_problem("done_mat_mul pulsed more than once");
                    @(negedge clk);
                    cyc++;
                end
                if (c_data_available) report_problem("c_data_available high for over four cycles");
            end
        end
        // Start is held for the whole run window with no second done pulse
        while (cyc < DONE_CYCLE + 6) begin
            if (done_mat_mul) report_problem("done_mat_mul pulsed more than once");
            @(negedge clk);
            cyc++;
        end
        @(posedge clk);
        start_mat_mul <= 1'b0;
    endtask

    initial begin
        integer           fd;
        integer           code;
        logic [8*32-1:0]  token;
        logic [8*256-1:0] rest;
        int               gap;
        bit               ok;
        errors        = 0;
        tests         = 0;
        seed          = 32'h084b_d2ee;
        test_name     = "reset";
        clk           = 1'b0;
        reset         = 1'b1;
        start_mat_mul = 1'b0;
        a_data        = '0;
        b_data        = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        check_idle();

        fd = $fopen("matmul_testdata.txt", "r");
        if (fd == 0) begin
            report_problem("could not open matmul_testdata.txt");
        end else begin
            code = $fscanf(fd, "%s", token);
            while (code == 1) begin
                if (token == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    test_name = $sformatf("%0s", token);
                    read_matrices(fd, ok);
                    if (ok) begin
                        run_matrix();
                        tests++;
                        // Random idle gap of 1 to 4 cycles with start low
                        gap = 1 + ($unsigned($random(seed)) % 4);
                        repeat (gap - 1) @(posedge clk);
                    end
                end
                code = $fscanf(fd, "%s", token);
            end
            $fclose(fd);
            if (tests == 0) report_problem("no tests found in the data file");
        end

        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
